// ==== all.f ====
aes_pkg.sv
aes_add_round_key.sv
aes_sub_shift.sv
aes_mix_columns.sv
aes_key_schedule.sv
aes_round_ctrl.sv
aes_enc_top.sv
tb_aes_enc.sv

// ==== tb_aes_enc.sv ====
`timescale 1ns/1ps

module tb_aes_enc;
    import aes_pkg::*;

    localparam logic [31:0]  LFSR_SEED      = 32'h5338b0d6;
    localparam logic [127:0] FIPS_KEY       = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] FIPS_PT        = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] FIPS_CT        = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam int           TIMEOUT_CYCLES = 50;   // far beyond the ten round latency
    localparam int           NUM_RANDOM     = 20;

    logic       clk;
    logic       resetn;
    logic       start;
    aes_state_u plaintext;
    aes_state_u key;
    aes_state_u ciphertext;
    logic       done;
    logic       busy;

    logic [31:0]  lfsr_state = LFSR_SEED;
    logic [127:0] expected;         // ciphertext that the next done must show
    int           errors = 0;
    int           done_count = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    aes_enc_top UUT (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .done       (done),
        .busy       (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci LFSR with taps 32 22 2 1 and the new bit entering at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step for every bit of the word
    task automatic random_word(output logic [127:0] v);
        for (int i = 0; i < 128; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[126:0], lfsr_state[0]};
        end
    endtask

    // product in GF(2^8) by shift and add with reduction by 0x1b
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // S-box from its definition as the inverse b^254 followed by the affine map
    function automatic logic [7:0] sbox_ref(input logic [7:0] b);
        logic [7:0] inv;
        logic [7:0] p;
        inv = 8'h01;
        p = b;
        for (int i = 0; i < 8; i++)
        begin
            if (i != 0)
                inv = gf_mul(inv, p);   // 254 has every bit set except bit 0
            p = gf_mul(p, p);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
                   ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // FIPS-197 encryption on byte arrays where byte i of a column word is row i mod 4
    function automatic logic [127:0] aes_ref_encrypt(input logic [127:0] pt,
                                                     input logic [127:0] ck);
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   rk [16];
        logic [7:0]   w [4];
        logic [7:0]   rc;
        logic [127:0] res;
        for (int i = 0; i < 16; i++)
        begin
            rk[i] = ck[127-8*i -: 8];
            s[i]  = pt[127-8*i -: 8] ^ rk[i];   // initial whitening
        end
        rc = 8'h01;
        for (int rnd = 1; rnd <= AES_ROUNDS; rnd++)
        begin
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    t[4*c+r] = sbox_ref(s[4*((c+r)%4)+r]);  // row r rotated left by r
            for (int c = 0; c < 4; c++)
            begin
                if (rnd == AES_ROUNDS)
                begin
                    for (int r = 0; r < 4; r++)
                        s[4*c+r] = t[4*c+r];    // last round has no MixColumns
                end
                else
                begin
                    s[4*c]   = gf_mul(t[4*c], 2) ^ gf_mul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
                    s[4*c+1] = t[4*c] ^ gf_mul(t[4*c+1], 2) ^ gf_mul(t[4*c+2], 3) ^ t[4*c+3];
                    s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gf_mul(t[4*c+2], 2) ^ gf_mul(t[4*c+3], 3);
                    s[4*c+3] = gf_mul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mul(t[4*c+3], 2);
                end
            end
            // next round key from the last word after rotation and substitution
            w[0] = sbox_ref(rk[13]) ^ rc;
            w[1] = sbox_ref(rk[14]);
            w[2] = sbox_ref(rk[15]);
            w[3] = sbox_ref(rk[12]);
            for (int i = 0; i < 4; i++)
                rk[i] = rk[i] ^ w[i];
            for (int i = 4; i < 16; i++)
                rk[i] = rk[i] ^ rk[i-4];        // each word chains from the one before
            rc = gf_mul(rc, 8'h02);
            for (int i = 0; i < 16; i++)
                s[i] = s[i] ^ rk[i];
        end
        for (int i = 0; i < 16; i++)
            res[127-8*i -: 8] = s[i];
        return res;
    endfunction

    task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // every done is checked against the expected ciphertext at the falling edge
    always @(negedge clk)
    begin
        if (resetn && done)
        begin
            done_count++;
            compare("ciphertext", ciphertext, expected);
        end
    end

    // one block with latency, busy and hold checks
    // inject sends a second start while the core is busy
    task automatic run_block(input logic [127:0] pt, input logic [127:0] k,
                             input logic [127:0] exp, input bit inject);
        int           n;
        bit           seen;
        int           dones_before;
        expected = exp;
        dones_before = done_count;
        @(posedge clk);
        start     <= 1'b1;
        plaintext <= pt;
        key       <= k;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT_CYCLES)
        begin
            @(posedge clk);             // the first pass is the edge that takes start
            if (inject && n == 3)
            begin
                start     <= 1'b1;      // the core is busy so this start must be dropped
                plaintext <= ~pt;
                key       <= pt ^ k;
            end
            else
                start <= 1'b0;
            @(negedge clk);
            n++;
            if (done)
                seen = 1'b1;
            else
                compare("busy", busy, 1'b1);
        end
        if (!seen)
        begin
            $display("done never came within %0d cycles of the start", TIMEOUT_CYCLES);
            errors++;
        end
        else
        begin
            compare("latency", n - 1, AES_ROUNDS);  // edges from start to the rise of done
            compare("busy", busy, 1'b0);
            for (int i = 0; i < (inject ? 12 : 1); i++)
            begin
                @(negedge clk);
                compare("done", done, 1'b0);    // single cycle and no second done
                compare("ciphertext", ciphertext, exp);
            end
            compare("done_count", done_count - dones_before, 1);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial
    begin
        logic [127:0] rk;
        logic [127:0] rp;
        int           e0;
        resetn    = 1'b0;
        start     = 1'b0;
        plaintext = '0;
        key       = '0;
        expected  = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        e0 = errors;
        @(negedge clk);
        compare("busy", busy, 1'b0);
        compare("done", done, 1'b0);
        compare("ciphertext", ciphertext, '0);
        end_test("reset", e0);

        e0 = errors;
        compare("reference", aes_ref_encrypt(FIPS_PT, FIPS_KEY), FIPS_CT);
        run_block(FIPS_PT, FIPS_KEY, FIPS_CT, 1'b0);
        end_test("fips-197 vector", e0);

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            e0 = errors;
            random_word(rk);
            random_word(rp);
            run_block(rp, rk, aes_ref_encrypt(rp, rk), 1'b0);
            end_test($sformatf("random block %0d", i), e0);
        end

        e0 = errors;
        random_word(rk);
        random_word(rp);
        run_block(rp, rk, aes_ref_encrypt(rp, rk), 1'b1);
        end_test("start while busy", e0);

        $display("%0d tests run, %0d ok, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== aes_enc_top.sv ====
`timescale 1ns/1ps

module aes_enc_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  aes_pkg::aes_state_u plaintext,
    input  aes_pkg::aes_state_u key,
    output aes_pkg::aes_state_u ciphertext,
    output logic                done,
    output logic                busy
);
    import aes_pkg::*;

    logic load;
    logic step;
    logic final_round;

    aes_state_u state;          // cipher state register output
    aes_state_u sub_shift_out;  // after SubBytes and ShiftRows
    aes_state_u round_out;      // after MixColumns, or bypassed in round ten
    aes_state_u next_key;       // key of the round being applied

    // sequencing of the ten rounds
    aes_round_ctrl u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .load        (load),
        .step        (step),
        .final_round (final_round),
        .busy        (busy),
        .done        (done)
    );

    aes_sub_shift u_sub_shift (
        .state_in  (state),
        .state_out (sub_shift_out)
    );

    aes_mix_columns u_mix_columns (
        .state_in    (sub_shift_out),
        .final_round (final_round),
        .state_out   (round_out)
    );

    aes_key_schedule u_key_schedule (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .step     (step),
        .key      (key),
        .next_key (next_key)
    );

    // holds the state, and the ciphertext once the last round is in
    aes_add_round_key u_add_round_key (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .step      (step),
        .plaintext (plaintext),
        .key       (key),
        .round_out (round_out),
        .next_key  (next_key),
        .state     (state)
    );

    assign ciphertext = state;

endmodule

// ==== aes_round_ctrl.sv ====
`timescale 1ns/1ps

module aes_round_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic start,         // single cycle request from the caller
    output logic load,          // initial whitening on this edge
    output logic step,          // one round on this edge
    output logic final_round,   // the round on this edge is the last one
    output logic busy,
    output logic done           // single cycle, ciphertext is valid
);
    import aes_pkg::*;

    logic [3:0] round;          // number of the round that the next step applies

    // a start that arrives while busy is dropped here
    assign load = start && !busy;

    // every busy cycle advances the cipher by one round
    assign step = busy;

    // round ten skips MixColumns
    assign final_round = busy && (round == AES_ROUNDS);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            done  <= 1'b0;
            round <= 4'd0;
        end
        else
        begin
            done <= 1'b0;                   // done only lasts one cycle
            if (load)
            begin
                busy  <= 1'b1;
                round <= 4'd1;              // round 1 is applied on the next edge
            end
            else if (step)
            begin
                if (final_round)
                begin
                    // last round goes in on this edge, so the result is ready after it
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    round <= 4'd0;
                end
                else
                begin
                    round <= round + 4'd1;
                end
            end
        end
    end

    // after the start edge busy stays high for exactly AES_ROUNDS cycles
    // done rises on the edge that clears busy, ten cycles after the start edge
    // the counter is zero whenever the core is idle

endmodule

// ==== aes_key_schedule.sv ====
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,       // start of a block, take the cipher key
    input  logic                step,       // one round applied, advance the key
    input  aes_pkg::aes_state_u key,
    output aes_pkg::aes_state_u next_key
);
    import aes_pkg::*;

    aes_state_u key_q;      // key of the round last applied, the cipher key after load
    logic [7:0] rcon_q;     // round constant for the key that next_key expands to

    logic [31:0] rot_word;  // last column rotated up by one byte
    logic [31:0] sub_word;  // that word through the S-box
    logic [31:0] temp;

    // RotWord turns {a0,a1,a2,a3} into {a1,a2,a3,a0}
    assign rot_word = {key_q.cols[3][23:0], key_q.cols[3][31:24]};

    // SubWord applies the S-box to every byte of the word
    assign sub_word = {aes_sbox(rot_word[31:24]), aes_sbox(rot_word[23:16]),
                       aes_sbox(rot_word[15:8]),  aes_sbox(rot_word[7:0])};

    // the round constant only touches the top byte of the word
    assign temp = sub_word ^ {rcon_q, 24'h000000};

    // each new column is chained from the one before it
    always_comb
    begin
        next_key         = '0;
        next_key.cols[0] = key_q.cols[0] ^ temp;
        next_key.cols[1] = key_q.cols[1] ^ next_key.cols[0];
        next_key.cols[2] = key_q.cols[2] ^ next_key.cols[1];
        next_key.cols[3] = key_q.cols[3] ^ next_key.cols[2];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_q  <= '0;
            rcon_q <= AES_RCON_INIT;
        end
        else if (load)
        begin
            key_q  <= key;              // round 1 expands from the cipher key
            rcon_q <= AES_RCON_INIT;
        end
        else if (step)
        begin
            key_q  <= next_key;         // add round key used this same value on this edge
            rcon_q <= aes_xtime(rcon_q);    // 01 02 04 .. 80 1b 36
        end
    end

endmodule

// ==== aes_mix_columns.sv ====
`timescale 1ns/1ps

module aes_mix_columns (
    input  aes_pkg::aes_state_u state_in,
    input  logic                final_round,    // last round leaves MixColumns out
    output aes_pkg::aes_state_u state_out
);
    import aes_pkg::*;

    // one column times the fixed matrix
    // rows of the matrix are {2 3 1 1}, {1 2 3 1}, {1 1 2 3}, {3 1 1 2}
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0, a1, a2, a3;
        logic [7:0] d0, d1, d2, d3;     // the doubled bytes
        logic [7:0] b0, b1, b2, b3;
        a0 = col[31:24];                // top byte is row 0
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        d0 = aes_xtime(a0);
        d1 = aes_xtime(a1);
        d2 = aes_xtime(a2);
        d3 = aes_xtime(a3);
        // times three is the doubled byte xor the byte itself
        b0 = d0 ^ (d1 ^ a1) ^ a2 ^ a3;
        b1 = a0 ^ d1 ^ (d2 ^ a2) ^ a3;
        b2 = a0 ^ a1 ^ d2 ^ (d3 ^ a3);
        b3 = (d0 ^ a0) ^ a1 ^ a2 ^ d3;
        return {b0, b1, b2, b3};
    endfunction

    always_comb
    begin
        if (final_round)
            state_out = state_in;   // round ten goes straight to AddRoundKey
        else
        begin
            state_out = '0;
            for (int c = 0; c < 4; c++)
                state_out.cols[c] = mix_column(state_in.cols[c]);  // columns are independent
        end
    end

endmodule

// ==== aes_sub_shift.sv ====
`timescale 1ns/1ps

module aes_sub_shift (
    input  aes_pkg::aes_state_u state_in,
    output aes_pkg::aes_state_u state_out
);
    import aes_pkg::*;

    // byte i of the state is row i mod 4 of column i div 4
    // row r moves left by r places, so output column c takes input column (c + r) mod 4
    always_comb
    begin
        state_out = '0;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                // substitute while the byte is being moved into place
                state_out.bytes[4*c + r] = aes_sbox(state_in.bytes[4*((c + r) % 4) + r]);
            end
        end
    end

    // row 0 is not shifted at all
    // row 1 moves one place, row 2 two places and row 3 three places
    // the S-box is the same for every byte, so doing it before or after the shift is alike
    // the whole stage is combinational and settles within the round cycle

endmodule

// ==== aes_add_round_key.sv ====
`timescale 1ns/1ps

module aes_add_round_key (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,       // take plaintext xor cipher key
    input  logic                step,       // take round result xor round key
    input  aes_pkg::aes_state_u plaintext,
    input  aes_pkg::aes_state_u key,
    input  aes_pkg::aes_state_u round_out,
    input  aes_pkg::aes_state_u next_key,
    output aes_pkg::aes_state_u state
);
    import aes_pkg::*;

    // the two operands of the whitening xor, chosen by the strobe
    aes_state_u data_sel;
    aes_state_u key_sel;

    assign data_sel = load ? plaintext : round_out;   // load wins, ctrl never raises both
    assign key_sel  = load ? key       : next_key;

    // cipher state register, after round ten it holds the ciphertext
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= '0;
        else if (load || step)
        begin
            for (int i = 0; i < 16; i++)
                state.bytes[i] <= data_sel.bytes[i] ^ key_sel.bytes[i];   // xor byte by byte
        end
    end

endmodule

// ==== aes_pkg.sv ====
package aes_pkg;

    // number of rounds for a 128 bit key
    localparam logic [3:0] AES_ROUNDS = 4'd10;

    // rcon of the first round, later ones come from doubling it
    localparam logic [7:0] AES_RCON_INIT = 8'h01;

    // one 128 bit AES state, byte 0 sits in the top bits as in FIPS-197
    // so column c is made of bytes 4c to 4c+3, with byte 4c in its top bits
    typedef union packed {
        logic [0:15][7:0] bytes;    // byte view used by SubBytes and ShiftRows
        logic [0:3][31:0] cols;     // column view used by MixColumns and the key schedule
    } aes_state_u;

    // forward S-box, entry 0 is the first byte of the first row
    localparam logic [0:255][7:0] AES_SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // byte substitution, a plain lookup into the table above
    function automatic logic [7:0] aes_sbox(input logic [7:0] b);
        return AES_SBOX_TABLE[b];
    endfunction

    // multiply by x in GF(2^8), reducing with the AES polynomial x^8+x^4+x^3+x+1
    function automatic logic [7:0] aes_xtime(input logic [7:0] b);
        logic [7:0] shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7])
        begin
            shifted = shifted ^ 8'h1b;    // the bit shifted out folds back as 0x1b
        end
        return shifted;
    endfunction

endpackage
